// File: design/irq_gateway.sv
// Level-mode interrupt gateway; holds pending and in-flight bits between sources and targets
`timescale 1ns/1ns
`default_nettype none

`include "periph_settings.svh"

module irq_gateway
    import periph_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  src_vec_t src_i,
    input  logic     claim_valid_i,
    input  src_id_t  claim_id_i,
    input  logic     complete_valid_i,
    input  src_id_t  complete_id_i,
    output src_vec_t pending_o
);

    src_vec_t pending_q;
    src_vec_t inflight_q;
    src_vec_t claim_hit;
    src_vec_t complete_hit;

    // One-hot decode of claim and complete IDs
    always_comb begin
        claim_hit    = '0;
        complete_hit = '0;
        if (claim_valid_i) begin
            claim_hit[claim_id_i] = 1'b1;
        end
        if (complete_valid_i) begin
            complete_hit[complete_id_i] = 1'b1;
        end
    end

    // --------------------
    // Pending and in flight
    // --------------------
    // A held line re-arms only after its completion
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q  <= '0;
            inflight_q <= '0;
        end else begin
            pending_q  <= (pending_q | (src_i & ~inflight_q)) & ~claim_hit;
            inflight_q <= (inflight_q & ~complete_hit) | claim_hit;
        end
    end

    assign pending_o = pending_q;

endmodule

`default_nettype wire

// File: design/irq_target.sv
// Per-target arbiter; picks the best pending enabled source above threshold and drives the line
`timescale 1ns/1ns
`default_nettype none

`include "periph_settings.svh"

module irq_target
    import periph_pkg::*;
(
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  src_vec_t                             pending_i,
    input  src_vec_t                             enable_i,
    input  prio_t [`PERIPH_NUM_SOURCES-1:0]      prio_i,
    input  prio_t                                thresh_i,
    output logic                                 irq_o,
    output src_id_t                              max_id_o
);

    src_vec_t active;
    prio_t    best_prio;
    src_id_t  best_id;
    src_id_t  max_id_q;

    assign active = pending_i & enable_i;

    // --------------------
    // Arbitration
    // --------------------
    // Starting from the threshold means only strictly higher priorities win;
    // strict compare also keeps the lowest number on a tie
    always_comb begin
        best_prio = thresh_i;
        best_id   = '0;
        for (int i = 1; i < `PERIPH_NUM_SOURCES; i++) begin
            if (active[i] && (prio_i[i] > best_prio)) begin
                best_prio = prio_i[i];
                best_id   = src_id_t'(i);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            max_id_q <= '0;
        end else begin
            max_id_q <= best_id;
        end
    end

    // Line is high whenever a winner is held
    assign irq_o    = (max_id_q != '0);
    assign max_id_o = max_id_q;

endmodule

`default_nettype wire

// File: design/irq_timer.sv
// Compare-match timer; each enabled channel pulses its interrupt once every cmp+1 cycles
`timescale 1ns/1ns
`default_nettype none

`include "periph_settings.svh"

module irq_timer
    import periph_pkg::*;
(
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,
    input  timer_val_t [`PERIPH_TIMER_CNT-1:0]     cmp_i,
    input  logic [`PERIPH_TIMER_CNT-1:0]           en_i,
    output logic [`PERIPH_TIMER_CNT-1:0]           evt_o
);

    timer_val_t [`PERIPH_TIMER_CNT-1:0] cnt_q;
    logic [`PERIPH_TIMER_CNT-1:0]       evt_q;

    // --------------------
    // Channel counters
    // --------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
            evt_q <= '0;
        end else begin
            for (int i = 0; i < `PERIPH_TIMER_CNT; i++) begin
                if (!en_i[i]) begin
                    // Disabled channel holds at zero
                    cnt_q[i] <= '0;
                    evt_q[i] <= 1'b0;
                end else if (cnt_q[i] == cmp_i[i]) begin
                    // Match, restart from zero
                    cnt_q[i] <= '0;
                    evt_q[i] <= 1'b1;
                end else begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                    evt_q[i] <= 1'b0;
                end
            end
        end
    end

    // One-cycle pulse per match
    assign evt_o = evt_q;

endmodule

`default_nettype wire

// File: design/periph_pkg.sv
// Shared types of the interrupt block; modules import it in their headers
`default_nettype none

`include "periph_settings.svh"

package periph_pkg;

    // One bit per interrupt source
    typedef logic [`PERIPH_NUM_SOURCES-1:0] src_vec_t;

    // Per-source priority, 0 never fires
    typedef logic [`PERIPH_PRIO_W-1:0] prio_t;

    // Source number, 0 is "none"
    typedef logic [$clog2(`PERIPH_NUM_SOURCES)-1:0] src_id_t;

    // Register port
    typedef logic [`PERIPH_REG_AW-1:0] reg_addr_t;
    typedef logic [`PERIPH_DATA_W-1:0] reg_data_t;

    // Timer counter and compare value
    typedef logic [`PERIPH_TIMER_W-1:0] timer_val_t;

endpackage

`default_nettype wire

// File: design/periph_regs.sv
// Register block; decodes word addresses, stores configuration and issues claims and completes
`timescale 1ns/1ns
`default_nettype none

`include "periph_settings.svh"

module periph_regs
    import periph_pkg::*;
(
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,
    input  logic                                    reg_valid_i,
    input  logic                                    reg_write_i,
    input  reg_addr_t                               reg_addr_i,
    input  reg_data_t                               reg_wdata_i,
    input  src_id_t [`PERIPH_NUM_TARGETS-1:0]       max_id_i,
    output reg_data_t                               reg_rdata_o,
    output logic                                    reg_ready_o,
    output prio_t [`PERIPH_NUM_SOURCES-1:0]         prio_o,
    output src_vec_t [`PERIPH_NUM_TARGETS-1:0]      enable_o,
    output prio_t [`PERIPH_NUM_TARGETS-1:0]         thresh_o,
    output timer_val_t [`PERIPH_TIMER_CNT-1:0]      timer_cmp_o,
    output logic [`PERIPH_TIMER_CNT-1:0]            timer_en_o,
    output logic                                    claim_valid_o,
    output src_id_t                                 claim_id_o,
    output logic                                    complete_valid_o,
    output src_id_t                                 complete_id_o
);

    prio_t [`PERIPH_NUM_SOURCES-1:0]     prio_q;
    src_vec_t [`PERIPH_NUM_TARGETS-1:0]  enable_q;
    prio_t [`PERIPH_NUM_TARGETS-1:0]     thresh_q;
    timer_val_t [`PERIPH_TIMER_CNT-1:0]  cmp_q;
    logic [`PERIPH_TIMER_CNT-1:0]        timer_en_q;
    logic                                ready_q;
    reg_data_t                           rdata_q;
    reg_data_t                           rd_data;
    logic                                rd_en;
    logic                                wr_en;
    logic [`PERIPH_NUM_SOURCES-1:0]      hit_prio;
    logic [`PERIPH_NUM_TARGETS-1:0]      hit_en;
    logic [`PERIPH_NUM_TARGETS-1:0]      hit_thr;
    logic [`PERIPH_NUM_TARGETS-1:0]      hit_claim;
    logic [`PERIPH_TIMER_CNT-1:0]        hit_cmp;
    logic                                hit_ten;

    assign rd_en = reg_valid_i & ~reg_write_i;
    assign wr_en = reg_valid_i & reg_write_i;

    // --------------------
    // Address decode
    // --------------------
    always_comb begin
        for (int i = 0; i < `PERIPH_NUM_SOURCES; i++) begin
            hit_prio[i] = (reg_addr_i == reg_addr_t'(`REG_PRIO_BASE + i));
        end
        for (int t = 0; t < `PERIPH_NUM_TARGETS; t++) begin
            hit_en[t]    = (reg_addr_i == reg_addr_t'(`REG_ENABLE_BASE + t));
            hit_thr[t]   = (reg_addr_i == reg_addr_t'(`REG_THRESH_BASE + t));
            hit_claim[t] = (reg_addr_i == reg_addr_t'(`REG_CLAIM_BASE + t));
        end
        for (int c = 0; c < `PERIPH_TIMER_CNT; c++) begin
            hit_cmp[c] = (reg_addr_i == reg_addr_t'(`REG_TIMER_CMP_BASE + c));
        end
        hit_ten = (reg_addr_i == reg_addr_t'(`REG_TIMER_EN));
    end

    // Read mux returns zero for unmapped words
    always_comb begin
        rd_data = '0;
        for (int i = 0; i < `PERIPH_NUM_SOURCES; i++) begin
            if (hit_prio[i]) begin
                rd_data = reg_data_t'(prio_q[i]);
            end
        end
        for (int t = 0; t < `PERIPH_NUM_TARGETS; t++) begin
            if (hit_en[t]) begin
                rd_data = reg_data_t'(enable_q[t]);
            end
            if (hit_thr[t]) begin
                rd_data = reg_data_t'(thresh_q[t]);
            end
            if (hit_claim[t]) begin
                rd_data = reg_data_t'(max_id_i[t]);
            end
        end
        for (int c = 0; c < `PERIPH_TIMER_CNT; c++) begin
            if (hit_cmp[c]) begin
                rd_data = reg_data_t'(cmp_q[c]);
            end
        end
        if (hit_ten) begin
            rd_data = reg_data_t'(timer_en_q);
        end
    end

    // --------------------
    // Claim and complete
    // --------------------
    // Issued in the access cycle so the gateway updates with the ready pulse
    always_comb begin
        claim_valid_o    = 1'b0;
        claim_id_o       = '0;
        complete_valid_o = 1'b0;
        complete_id_o    = '0;
        for (int t = 0; t < `PERIPH_NUM_TARGETS; t++) begin
            if (hit_claim[t] && rd_en && (max_id_i[t] != '0)) begin
                claim_valid_o = 1'b1;
                claim_id_o    = max_id_i[t];
            end
            if (hit_claim[t] && wr_en) begin
                complete_valid_o = 1'b1;
                complete_id_o    = reg_wdata_i[$bits(src_id_t)-1:0];
            end
        end
    end

    // --------------------
    // Storage
    // --------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prio_q     <= '0;
            enable_q   <= '0;
            thresh_q   <= '0;
            cmp_q      <= '0;
            timer_en_q <= '0;
            ready_q    <= 1'b0;
            rdata_q    <= '0;
        end else begin
            ready_q <= reg_valid_i;
            // Read data is presented in the ready cycle
            rdata_q <= rd_en ? rd_data : '0;
            if (wr_en) begin
                for (int i = 0; i < `PERIPH_NUM_SOURCES; i++) begin
                    if (hit_prio[i]) begin
                        prio_q[i] <= reg_wdata_i[`PERIPH_PRIO_W-1:0];
                    end
                end
                for (int t = 0; t < `PERIPH_NUM_TARGETS; t++) begin
                    if (hit_en[t]) begin
                        enable_q[t] <= reg_wdata_i[`PERIPH_NUM_SOURCES-1:0];
                    end
                    if (hit_thr[t]) begin
                        thresh_q[t] <= reg_wdata_i[`PERIPH_PRIO_W-1:0];
                    end
                end
                for (int c = 0; c < `PERIPH_TIMER_CNT; c++) begin
                    if (hit_cmp[c]) begin
                        cmp_q[c] <= reg_wdata_i[`PERIPH_TIMER_W-1:0];
                    end
                end
                if (hit_ten) begin
                    timer_en_q <= reg_wdata_i[`PERIPH_TIMER_CNT-1:0];
                end
            end
        end
    end

    assign reg_ready_o = ready_q;
    assign reg_rdata_o = rdata_q;
    assign prio_o      = prio_q;
    assign enable_o    = enable_q;
    assign thresh_o    = thresh_q;
    assign timer_cmp_o = cmp_q;
    assign timer_en_o  = timer_en_q;

endmodule

`default_nettype wire

// File: design/periph_settings.svh
// Sizes, source numbers and register word map of the interrupt block, included where needed
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

// --------------------
// Sizes
// --------------------
`define PERIPH_NUM_SOURCES 16
`define PERIPH_NUM_TARGETS 2
`define PERIPH_PRIO_W 3
`define PERIPH_TIMER_CNT 4
`define PERIPH_TIMER_W 16
`define PERIPH_REG_AW 6
`define PERIPH_DATA_W 32

// --------------------
// Source numbers
// --------------------
// Source 0 means no interrupt, 14 and 15 are reserved
`define SRC_UART 1
`define SRC_ETH 2
`define SRC_TIMER0 3
`define SRC_C2H 7
`define SRC_CLUSTER_EOC 8
`define SRC_MBOX 9
`define SRC_PWM0 10

// --------------------
// Register word addresses
// --------------------
`define REG_PRIO_BASE 0
`define REG_ENABLE_BASE 16
`define REG_THRESH_BASE 20
`define REG_CLAIM_BASE 24
`define REG_TIMER_CMP_BASE 32
`define REG_TIMER_EN 40

`endif

// File: design/periph_top.sv
// Top level of the interrupt block; maps system lines to sources and links timer, gateway, targets
`timescale 1ns/1ns
`default_nettype none

`include "periph_settings.svh"

module periph_top
    import periph_pkg::*;
(
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              reg_valid_i,
    input  logic                              reg_write_i,
    input  reg_addr_t                         reg_addr_i,
    input  reg_data_t                         reg_wdata_i,
    input  logic                              uart_irq_i,
    input  logic                              eth_irq_i,
    input  logic                              c2h_irq_i,
    input  logic                              cluster_eoc_i,
    input  logic                              irq_mbox_i,
    input  logic [3:0]                        pwm_irq_i,
    output reg_data_t                         reg_rdata_o,
    output logic                              reg_ready_o,
    output logic [`PERIPH_NUM_TARGETS-1:0]    irq_o
);

    src_vec_t                            irq_src;
    src_vec_t                            pending;
    logic [`PERIPH_TIMER_CNT-1:0]        timer_evt;
    timer_val_t [`PERIPH_TIMER_CNT-1:0]  timer_cmp;
    logic [`PERIPH_TIMER_CNT-1:0]        timer_en;
    prio_t [`PERIPH_NUM_SOURCES-1:0]     prio;
    src_vec_t [`PERIPH_NUM_TARGETS-1:0]  enable;
    prio_t [`PERIPH_NUM_TARGETS-1:0]     thresh;
    src_id_t [`PERIPH_NUM_TARGETS-1:0]   max_id;
    logic                                claim_valid;
    src_id_t                             claim_id;
    logic                                complete_valid;
    src_id_t                             complete_id;

    // --------------------
    // Source map
    // --------------------
    // Source 0 and the reserved numbers stay low
    always_comb begin
        irq_src                                     = '0;
        irq_src[`SRC_UART]                          = uart_irq_i;
        irq_src[`SRC_ETH]                           = eth_irq_i;
        irq_src[`SRC_TIMER0 +: `PERIPH_TIMER_CNT]   = timer_evt;
        irq_src[`SRC_C2H]                           = c2h_irq_i;
        irq_src[`SRC_CLUSTER_EOC]                   = cluster_eoc_i;
        irq_src[`SRC_MBOX]                          = irq_mbox_i;
        irq_src[`SRC_PWM0 +: 4]                     = pwm_irq_i;
    end

    periph_regs u_regs (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .reg_valid_i      (reg_valid_i),
        .reg_write_i      (reg_write_i),
        .reg_addr_i       (reg_addr_i),
        .reg_wdata_i      (reg_wdata_i),
        .max_id_i         (max_id),
        .reg_rdata_o      (reg_rdata_o),
        .reg_ready_o      (reg_ready_o),
        .prio_o           (prio),
        .enable_o         (enable),
        .thresh_o         (thresh),
        .timer_cmp_o      (timer_cmp),
        .timer_en_o       (timer_en),
        .claim_valid_o    (claim_valid),
        .claim_id_o       (claim_id),
        .complete_valid_o (complete_valid),
        .complete_id_o    (complete_id)
    );

    irq_timer u_timer (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .cmp_i   (timer_cmp),
        .en_i    (timer_en),
        .evt_o   (timer_evt)
    );

    irq_gateway u_gateway (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .src_i            (irq_src),
        .claim_valid_i    (claim_valid),
        .claim_id_i       (claim_id),
        .complete_valid_i (complete_valid),
        .complete_id_i    (complete_id),
        .pending_o        (pending)
    );

    // Machine target
    irq_target u_target_m (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .pending_i (pending),
        .enable_i  (enable[0]),
        .prio_i    (prio),
        .thresh_i  (thresh[0]),
        .irq_o     (irq_o[0]),
        .max_id_o  (max_id[0])
    );

    // Supervisor target
    irq_target u_target_s (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .pending_i (pending),
        .enable_i  (enable[1]),
        .prio_i    (prio),
        .thresh_i  (thresh[1]),
        .irq_o     (irq_o[1]),
        .max_id_o  (max_id[1])
    );

endmodule

`default_nettype wire

// File: verification/periph_sva.sv
// Concurrent checks on register port timing, interrupt lines in reset and claim IDs; bound to the top
`timescale 1ns/1ns
`default_nettype none

`include "periph_settings.svh"

module periph_sva
    import periph_pkg::*;
(
    input logic                           clk_i,
    input logic                           rst_n_i,
    input logic                           reg_valid_i,
    input logic                           reg_ready_i,
    input logic [`PERIPH_NUM_TARGETS-1:0] irq_i,
    input logic                           claim_valid_i,
    input src_id_t                        claim_id_i
);

    int unsigned fail_count = 0;

    // --------------------
    // Register port
    // --------------------
    ready_follows_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        reg_valid_i |=> reg_ready_i)
        else begin
            $error("reg_ready_o did not follow reg_valid_i by one cycle");
            fail_count++;
        end

    ready_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        reg_ready_i |-> $past(reg_valid_i))
        else begin
            $error("reg_ready_o pulsed without an access one cycle earlier");
            fail_count++;
        end

    // --------------------
    // Interrupt side
    // --------------------
    irq_low_in_reset: assert property (@(posedge clk_i)
        !rst_n_i |-> (irq_i == '0))
        else begin
            $error("irq_o is not low during reset");
            fail_count++;
        end

    // Source 0 means no interrupt and is never claimed
    claim_id_nonzero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        claim_valid_i |-> (claim_id_i != '0))
        else begin
            $error("claim issued for source 0");
            fail_count++;
        end

endmodule

bind periph_top periph_sva u_sva (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .reg_valid_i   (reg_valid_i),
    .reg_ready_i   (reg_ready_o),
    .irq_i         (irq_o),
    .claim_valid_i (claim_valid),
    .claim_id_i    (claim_id)
);

`default_nettype wire

// File: verification/periph_tb.sv
// Testbench top of the interrupt block; random register traffic and claims checked against a model
`timescale 1ns/1ns
`default_nettype none

`include "periph_settings.svh"

module periph_tb
    import periph_pkg::*;
();

    localparam int READY_TIMEOUT = 20;
    localparam int IRQ_TIMEOUT   = 50;

    // Source positions driven by external lines
    localparam src_vec_t EXT_LINES = (src_vec_t'(1) << `SRC_UART) | (src_vec_t'(1) << `SRC_ETH)
        | (src_vec_t'(1) << `SRC_C2H) | (src_vec_t'(1) << `SRC_CLUSTER_EOC)
        | (src_vec_t'(1) << `SRC_MBOX) | (src_vec_t'(15) << `SRC_PWM0);

    logic        clk;
    logic        rst_n;
    logic        reg_valid;
    logic        reg_write;
    reg_addr_t   reg_addr;
    reg_data_t   reg_wdata;
    reg_data_t   reg_rdata;
    logic        reg_ready;
    logic [1:0]  irq;
    logic        uart_irq;
    logic        eth_irq;
    logic        c2h_irq;
    logic        cluster_eoc;
    logic        irq_mbox;
    logic [3:0]  pwm_irq;

    int          errors;
    logic [31:0] rng_state;

    // Model state
    prio_t       sh_prio [`PERIPH_NUM_SOURCES];
    src_vec_t    sh_enable [`PERIPH_NUM_TARGETS];
    prio_t       sh_thresh [`PERIPH_NUM_TARGETS];
    timer_val_t  sh_cmp [`PERIPH_TIMER_CNT];
    logic [3:0]  sh_ten;
    src_vec_t    sh_lines;
    src_vec_t    sh_pend;
    src_vec_t    sh_infl;

    tb_clock_gen u_clock (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    periph_top DUT (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .reg_valid_i   (reg_valid),
        .reg_write_i   (reg_write),
        .reg_addr_i    (reg_addr),
        .reg_wdata_i   (reg_wdata),
        .uart_irq_i    (uart_irq),
        .eth_irq_i     (eth_irq),
        .c2h_irq_i     (c2h_irq),
        .cluster_eoc_i (cluster_eoc),
        .irq_mbox_i    (irq_mbox),
        .pwm_irq_i     (pwm_irq),
        .reg_rdata_o   (reg_rdata),
        .reg_ready_o   (reg_ready),
        .irq_o         (irq)
    );

    // --------------------
    // Random numbers and model
    // --------------------
    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state ^ (rng_state >> 15);
    endfunction

    // Latched levels stay pending until claimed; timer channels count as fired
    function automatic void settle_pending();
        sh_pend = sh_pend | ((sh_lines | (src_vec_t'(sh_ten) << `SRC_TIMER0)) & ~sh_infl);
        sh_pend[0] = 1'b0;
    endfunction

    // Highest priority strictly above threshold with ties to the lowest number
    function automatic src_id_t best_source(input int t);
        prio_t   best;
        src_id_t id;
        best = sh_thresh[t];
        id   = '0;
        for (int i = 1; i < `PERIPH_NUM_SOURCES; i++) begin
            if (sh_pend[i] && sh_enable[t][i] && (sh_prio[i] > best)) begin
                best = sh_prio[i];
                id   = src_id_t'(i);
            end
        end
        return id;
    endfunction

    function automatic reg_data_t expected_rdata(input int addr);
        if (addr >= `REG_PRIO_BASE && addr < `REG_PRIO_BASE + `PERIPH_NUM_SOURCES) begin
            return reg_data_t'(sh_prio[addr - `REG_PRIO_BASE]);
        end
        if (addr >= `REG_ENABLE_BASE && addr < `REG_ENABLE_BASE + `PERIPH_NUM_TARGETS) begin
            return reg_data_t'(sh_enable[addr - `REG_ENABLE_BASE]);
        end
        if (addr >= `REG_THRESH_BASE && addr < `REG_THRESH_BASE + `PERIPH_NUM_TARGETS) begin
            return reg_data_t'(sh_thresh[addr - `REG_THRESH_BASE]);
        end
        if (addr >= `REG_TIMER_CMP_BASE && addr < `REG_TIMER_CMP_BASE + `PERIPH_TIMER_CNT) begin
            return reg_data_t'(sh_cmp[addr - `REG_TIMER_CMP_BASE]);
        end
        if (addr == `REG_TIMER_EN) begin
            return reg_data_t'(sh_ten);
        end
        return '0;
    endfunction

    // Field widths mask the stored value and unmapped words keep nothing
    function automatic void update_shadow(input int addr, input reg_data_t data);
        if (addr >= `REG_PRIO_BASE && addr < `REG_PRIO_BASE + `PERIPH_NUM_SOURCES) begin
            sh_prio[addr - `REG_PRIO_BASE] = data[`PERIPH_PRIO_W-1:0];
        end
        if (addr >= `REG_ENABLE_BASE && addr < `REG_ENABLE_BASE + `PERIPH_NUM_TARGETS) begin
            sh_enable[addr - `REG_ENABLE_BASE] = data[`PERIPH_NUM_SOURCES-1:0];
        end
        if (addr >= `REG_THRESH_BASE && addr < `REG_THRESH_BASE + `PERIPH_NUM_TARGETS) begin
            sh_thresh[addr - `REG_THRESH_BASE] = data[`PERIPH_PRIO_W-1:0];
        end
        if (addr >= `REG_TIMER_CMP_BASE && addr < `REG_TIMER_CMP_BASE + `PERIPH_TIMER_CNT) begin
            sh_cmp[addr - `REG_TIMER_CMP_BASE] = data[`PERIPH_TIMER_W-1:0];
        end
        if (addr == `REG_TIMER_EN) begin
            sh_ten = data[`PERIPH_TIMER_CNT-1:0];
        end
    endfunction

    // --------------------
    // Checks and bus access
    // --------------------
    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("FAIL t=%0t %s actual=0x%0h expected=0x%0h", $time, name, actual,
                     expected);
        end
    endtask

    // Ready is sampled on the falling edge, where it is stable
    task automatic wait_ready(output reg_data_t data);
        int n;
        n    = 0;
        data = '0;
        @(negedge clk);
        while (reg_ready !== 1'b1 && n < READY_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (reg_ready !== 1'b1) begin
            errors++;
            $display("Timeout at %0t: no register ready within %0d cycles", $time, n);
        end else begin
            data = reg_rdata;
        end
    endtask

    task automatic access(input logic write, input int addr, input reg_data_t wdata,
                          output reg_data_t rdata);
        @(posedge clk);
        reg_valid <= 1'b1;
        reg_write <= write;
        reg_addr  <= reg_addr_t'(addr);
        reg_wdata <= wdata;
        @(posedge clk);
        reg_valid <= 1'b0;
        reg_write <= 1'b0;
        wait_ready(rdata);
    endtask

    task automatic write_word(input int addr, input reg_data_t data);
        reg_data_t unused;
        access(1'b1, addr, data, unused);
        update_shadow(addr, data);
    endtask

    task automatic read_and_check(input int addr);
        reg_data_t rd;
        access(1'b0, addr, '0, rd);
        compare_value($sformatf("reg_rdata_o (word %0d)", addr), rd, expected_rdata(addr));
    endtask

    task automatic wait_for_irq(input int t, input logic expected);
        int n;
        n = 0;
        @(negedge clk);
        while (irq[t] !== expected && n < IRQ_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (irq[t] !== expected) begin
            errors++;
            $display("Timeout at %0t: irq_o[%0d] did not settle to %0b within %0d cycles",
                     $time, t, expected, n);
        end
    endtask

    task automatic claim_and_check(input int t, output src_id_t got);
        src_id_t   exp;
        reg_data_t rd;
        settle_pending();
        exp = best_source(t);
        wait_for_irq(t, exp != '0);
        access(1'b0, `REG_CLAIM_BASE + t, '0, rd);
        compare_value($sformatf("reg_rdata_o (claim, target %0d)", t), rd, 32'(exp));
        got = src_id_t'(rd);
        if (exp != '0) begin
            sh_pend[exp] = 1'b0;
            sh_infl[exp] = 1'b1;
        end
    endtask

    task automatic complete_source(input int t, input int id);
        write_word(`REG_CLAIM_BASE + t, reg_data_t'(id));
        sh_infl[id] = 1'b0;
    endtask

    // Lines are held; pending and irq_o follow within 2 cycles
    task automatic drive_lines(input src_vec_t mask);
        @(posedge clk);
        uart_irq    <= mask[`SRC_UART];
        eth_irq     <= mask[`SRC_ETH];
        c2h_irq     <= mask[`SRC_C2H];
        cluster_eoc <= mask[`SRC_CLUSTER_EOC];
        irq_mbox    <= mask[`SRC_MBOX];
        pwm_irq     <= mask[`SRC_PWM0 +: 4];
        sh_lines = mask & EXT_LINES;
        repeat (3) @(posedge clk);
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        int        addr;
        int        n;
        int        cmp;
        int        max_cmp;
        src_id_t   got;

        reg_valid   = 1'b0;
        reg_write   = 1'b0;
        reg_addr    = '0;
        reg_wdata   = '0;
        uart_irq    = 1'b0;
        eth_irq     = 1'b0;
        c2h_irq     = 1'b0;
        cluster_eoc = 1'b0;
        irq_mbox    = 1'b0;
        pwm_irq     = '0;
        errors      = 0;
        rng_state   = 32'd95902;
        sh_ten      = '0;
        sh_lines    = '0;
        sh_pend     = '0;
        sh_infl     = '0;
        foreach (sh_prio[i]) sh_prio[i] = '0;
        foreach (sh_enable[t]) sh_enable[t] = '0;
        foreach (sh_thresh[t]) sh_thresh[t] = '0;
        foreach (sh_cmp[c]) sh_cmp[c] = '0;

        n = 0;
        while (rst_n !== 1'b1 && n < 50) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            errors++;
            $display("Timeout at %0t: reset was never released", $time);
        end

        // Reset state
        @(negedge clk);
        compare_value("irq_o", 32'(irq), 32'd0);
        read_and_check(`REG_PRIO_BASE + 5);
        read_and_check(`REG_ENABLE_BASE + 1);
        read_and_check(`REG_THRESH_BASE);
        read_and_check(`REG_TIMER_CMP_BASE + 2);

        // Random writes with readback that skip the claim words and timer enable
        repeat (40) begin
            addr = int'(lcg_next() % 64);
            if (addr == `REG_CLAIM_BASE || addr == `REG_CLAIM_BASE + 1
                    || addr == `REG_TIMER_EN) begin
                addr = addr + 2;
            end
            write_word(addr, lcg_next());
            read_and_check(addr);
        end

        // Random arbitration setup with held external lines
        for (int i = 1; i < `PERIPH_NUM_SOURCES; i++) begin
            write_word(`REG_PRIO_BASE + i, lcg_next() % 8);
        end
        for (int t = 0; t < `PERIPH_NUM_TARGETS; t++) begin
            write_word(`REG_ENABLE_BASE + t, lcg_next());
            write_word(`REG_THRESH_BASE + t, lcg_next() % 4);
        end
        drive_lines((src_vec_t'(lcg_next()) | (src_vec_t'(1) << `SRC_UART)) & EXT_LINES);
        claim_and_check(0, got);
        claim_and_check(1, got);

        // Held sources stay out of claims until completed
        write_word(`REG_ENABLE_BASE, 32'h0000_fffe);
        write_word(`REG_THRESH_BASE, 0);
        write_word(`REG_PRIO_BASE + `SRC_UART, 1 + lcg_next() % 7);
        for (int k = 0; k < `PERIPH_NUM_SOURCES; k++) begin
            claim_and_check(0, got);
            if (got == '0) begin
                break;
            end
        end
        for (int i = 1; i < `PERIPH_NUM_SOURCES; i++) begin
            if (sh_infl[i]) begin
                complete_source(0, i);
            end
        end
        claim_and_check(0, got);
        claim_and_check(0, got);

        // Threshold at the top priority silences each target
        // The held UART line keeps both targets raised beforehand
        for (int i = 1; i < `PERIPH_NUM_SOURCES; i++) begin
            if (sh_infl[i]) begin
                complete_source(0, i);
            end
        end
        write_word(`REG_ENABLE_BASE + 1, 32'h0000_fffe);
        write_word(`REG_THRESH_BASE + 1, 0);
        for (int t = 0; t < `PERIPH_NUM_TARGETS; t++) begin
            wait_for_irq(t, 1'b1);
            write_word(`REG_THRESH_BASE + t, 7);
            claim_and_check(t, got);
            compare_value($sformatf("irq_o[%0d]", t), 32'(irq[t]), 32'd0);
        end

        // Timer channels join the external lines
        write_word(`REG_THRESH_BASE, 0);
        write_word(`REG_ENABLE_BASE, 32'h0000_fffe);
        max_cmp = 0;
        for (int c = 0; c < `PERIPH_TIMER_CNT; c++) begin
            write_word(`REG_PRIO_BASE + `SRC_TIMER0 + c, 1 + lcg_next() % 7);
            cmp = 2 + int'(lcg_next() % 30);
            write_word(`REG_TIMER_CMP_BASE + c, cmp);
            if (cmp > max_cmp) begin
                max_cmp = cmp;
            end
        end
        write_word(`REG_TIMER_EN, 1 + lcg_next() % 15);
        // First pulse comes after cmp+1 cycles and pending and max_id follow
        repeat (max_cmp + 6) @(posedge clk);
        for (int k = 0; k < `PERIPH_NUM_SOURCES; k++) begin
            claim_and_check(0, got);
            if (got == '0) begin
                break;
            end
        end

        $display("Summary: %0d check errors, %0d assertion failures", errors,
                 DUT.u_sva.fail_count);
        if (errors == 0 && DUT.u_sva.fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
// Clock and reset source for the testbench; 10 ns clock, reset held low for 8 cycles
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Release on a rising edge after 8 cycles
    initial begin
        rst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+design
design/periph_pkg.sv
design/irq_timer.sv
design/irq_gateway.sv
design/irq_target.sv
design/periph_regs.sv
design/periph_top.sv
verification/tb_clock_gen.sv
verification/periph_sva.sv
verification/periph_tb.sv
